//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP ?= vliwCoreTb
FILELIST ?= list.f
BUILD_DIR ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- list.f
+incdir+include
src/coreTypesPkg.sv
src/arithmeticUnit.sv
src/registerFile.sv
src/laneDecoder.sv
src/instructionCache.sv
src/icacheLoader.sv
src/coreControl.sv
src/vliwCore.sv
verification/vliwCoreTb.sv

//--- src/arithmeticUnit.sv
`timescale 1ns/1ps

module arithmeticUnit (
	input  logic clock_i,
	input  logic reset_i,
	input  logic opValid_i,
	input  logic [6:0] opCode_i,
	input  logic [coreTypesPkg::RegAddrWidth-1:0] rd_i,
	input  logic [coreTypesPkg::DataWidth-1:0] opA_i,
	input  logic [coreTypesPkg::DataWidth-1:0] opB_i,
	output logic resultValid_o,
	output logic [coreTypesPkg::RegAddrWidth-1:0] resultAddr_o,
	output logic [coreTypesPkg::DataWidth-1:0] result_o,
	output logic wbValid_o,
	output logic wbEnable_o,
	output logic [coreTypesPkg::RegAddrWidth-1:0] wbAddr_o,
	output logic [coreTypesPkg::DataWidth-1:0] wbData_o
);
	// 16 bit wraparound throughout
	always_comb
	begin
		case (opCode_i)
			coreTypesPkg::OpAdd: result_o = opA_i + opB_i;
			coreTypesPkg::OpSub: result_o = opA_i - opB_i;
			coreTypesPkg::OpAnd: result_o = opA_i & opB_i;
			coreTypesPkg::OpOr: result_o = opA_i | opB_i;
			coreTypesPkg::OpXor: result_o = opA_i ^ opB_i;
			default: result_o = '0;
		endcase
	end

	// decoder already zeroed rd for anything that does not write
	assign resultValid_o = opValid_i && (rd_i != '0);
	assign resultAddr_o = rd_i;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			wbValid_o <= 1'b0;
			wbEnable_o <= 1'b0;
		end
		else
		begin
			wbValid_o <= opValid_i;
			wbEnable_o <= resultValid_o;
		end
	end

	// quiet beat shows zero address and data
	always_ff @(posedge clock_i)
	begin
		wbAddr_o <= resultValid_o ? rd_i : '0;
		wbData_o <= resultValid_o ? result_o : '0;
	end

endmodule

//--- src/coreControl.sv
`timescale 1ns/1ps

module coreControl #(
	parameter int CreditCount = 4
) (
	input  logic clock_i,
	input  logic reset_i,
	input  logic run_i,
	input  logic creditReturn_i,
	input  logic bundleValid_i,
	input  logic branchTaken_i,
	input  logic [coreTypesPkg::PcWidth-1:0] branchTarget_i,
	input  logic haltSeen_i,
	output logic fetchValid_o,
	output logic [coreTypesPkg::PcWidth-1:0] fetchPc_o,
	output logic squash_o,
	output logic halted_o
);
	// spare top bit, an overrun shows up instead of wrapping
	localparam int CreditWidth = $clog2(CreditCount + 1) + 1;
	localparam logic [coreTypesPkg::PcWidth-1:0] BundleStep = 8;

	logic [coreTypesPkg::PcWidth-1:0] pc;
	logic [coreTypesPkg::PcWidth-1:0] fetchSource;
	logic [CreditWidth-1:0] credits;
	logic halted;
	logic branchRedirect;
	logic haltNow;
	logic fetchGo;
	logic creditRestore;

	////////////////////
	// redirect
	////////////////////

	// lane b result seen while its bundle is in decode
	assign branchRedirect = bundleValid_i && branchTaken_i;
	assign haltNow = bundleValid_i && haltSeen_i;

	// the bundle behind it is still in fetch, kill it
	assign squash_o = branchRedirect || haltNow;

	// that bundle held a credit only if it was really fetched
	assign creditRestore = squash_o && fetchValid_o;

	////////////////////
	// fetch
	////////////////////

	// no new fetch once a halt is decoded
	assign fetchGo = run_i && !halted && !haltNow && (credits != '0);
	assign fetchSource = branchRedirect ? branchTarget_i : pc;
	assign halted_o = halted;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			pc <= '0;
			fetchPc_o <= '0;
			fetchValid_o <= 1'b0;
			credits <= CreditWidth'(CreditCount);
			halted <= 1'b0;
		end
		else
		begin
			// take one per fetch, give back squashed and returned ones
			credits <= credits - CreditWidth'(fetchGo) + CreditWidth'(creditRestore)
				+ CreditWidth'(creditReturn_i);
			fetchValid_o <= fetchGo;
			if (haltNow)
				halted <= 1'b1;
			if (fetchGo)
			begin
				// target goes straight out on a taken branch
				fetchPc_o <= fetchSource;
				pc <= fetchSource + BundleStep;
			end
			else if (branchRedirect)
				pc <= branchTarget_i;
		end
	end

	// the consumer must never hand back more than it was given
	creditBound: assert property (@(posedge clock_i) disable iff (reset_i)
		credits <= CreditWidth'(CreditCount));

endmodule

//--- src/coreTypesPkg.sv
package coreTypesPkg;

	////////////////////
	// datapath widths
	////////////////////

	// one data word
	localparam int DataWidth = 16;
	localparam int RegCount = 32;
	localparam int RegAddrWidth = 5;

	// two instructions make one bundle
	localparam int InstrWidth = 32;
	localparam int BundleWidth = 2 * InstrWidth;

	// cacheline geometry
	localparam int LineBytes = 32;
	localparam int LineWidth = LineBytes * 8;
	localparam int BundlesPerLine = LineWidth / BundleWidth;

	// byte address, bundles are 8 bytes apart
	localparam int PcWidth = 16;

	// sign extended up to DataWidth
	localparam int ImmWidth = 14;

	////////////////////
	// opcodes
	////////////////////

	// anything not listed here behaves as a nop
	localparam logic [6:0] OpNop = 7'd0;
	localparam logic [6:0] OpAdd = 7'd1;
	localparam logic [6:0] OpSub = 7'd2;
	localparam logic [6:0] OpAnd = 7'd3;
	localparam logic [6:0] OpOr = 7'd4;
	localparam logic [6:0] OpXor = 7'd5;
	localparam logic [6:0] OpBeqz = 7'd6;
	localparam logic [6:0] OpHalt = 7'd7;

	// instruction word, format bit picks the view
	// 0 selects reg-reg, 1 selects reg-imm
	typedef union packed {
		struct packed {
			logic [6:0] opcode;
			logic format;
			logic [RegAddrWidth-1:0] rd;
			logic [RegAddrWidth-1:0] rs1;
			logic [RegAddrWidth-1:0] rs2;
			logic [8:0] spare;
		} regReg;
		struct packed {
			logic [6:0] opcode;
			logic format;
			logic [RegAddrWidth-1:0] rd;
			logic [RegAddrWidth-1:0] rs1;
			logic [ImmWidth-1:0] imm;
		} regImm;
	} instrWord_u;

endpackage

//--- src/icacheLoader.sv
`timescale 1ns/1ps

module icacheLoader #(
	parameter int CacheLines = 16
) (
	input  logic clock_i,
	input  logic reset_i,
	input  logic shiftValid_i,
	input  logic [7:0] shiftByte_i,
	input  logic lineWrite_i,
	input  logic [$clog2(CacheLines)-1:0] lineAddr_i,
	output logic cacheWrite_o,
	output logic [$clog2(CacheLines)-1:0] cacheWriteAddr_o,
	output logic [coreTypesPkg::LineWidth-1:0] cacheWriteLine_o
);
	logic [coreTypesPkg::LineWidth-1:0] shiftBuffer;

	// bytes enter at the top and drift down
	// after a full line the first byte sits in byte 0
	always_ff @(posedge clock_i)
	begin
		if (shiftValid_i)
			shiftBuffer <= {shiftByte_i, shiftBuffer[coreTypesPkg::LineWidth-1:8]};
		cacheWriteAddr_o <= lineAddr_i;
		cacheWriteLine_o <= shiftBuffer;
	end

	// write strobe lasts one cycle per request
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			cacheWrite_o <= 1'b0;
		else
			cacheWrite_o <= lineWrite_i;
	end

endmodule

//--- src/instructionCache.sv
`timescale 1ns/1ps

module instructionCache #(
	parameter int CacheLines = 16
) (
	input  logic clock_i,
	input  logic reset_i,
	input  logic cacheWrite_i,
	input  logic [$clog2(CacheLines)-1:0] cacheWriteAddr_i,
	input  logic [coreTypesPkg::LineWidth-1:0] cacheWriteLine_i,
	input  logic fetchValid_i,
	input  logic [coreTypesPkg::PcWidth-1:0] fetchPc_i,
	input  logic squash_i,
	output logic [coreTypesPkg::BundleWidth-1:0] bundle_o,
	output logic [coreTypesPkg::PcWidth-1:0] bundlePc_o,
	output logic bundleValid_o
);
	localparam int OffsetBits = $clog2(coreTypesPkg::LineBytes);
	localparam int SelectBits = $clog2(coreTypesPkg::BundlesPerLine);
	localparam int IndexWidth = $clog2(CacheLines);

	logic [coreTypesPkg::LineWidth-1:0] lines [CacheLines];
	logic [IndexWidth-1:0] readIndex;
	logic [SelectBits-1:0] readSelect;

	// pc split: line index above the byte offset, bundle select just below it
	assign readIndex = fetchPc_i[OffsetBits +: IndexWidth];
	assign readSelect = fetchPc_i[OffsetBits-SelectBits +: SelectBits];

	always_ff @(posedge clock_i)
	begin
		if (cacheWrite_i)
			lines[cacheWriteAddr_i] <= cacheWriteLine_i;
		bundle_o <= lines[readIndex][readSelect * coreTypesPkg::BundleWidth +:
			coreTypesPkg::BundleWidth];
		bundlePc_o <= fetchPc_i;
	end

	// squash drops the bundle being latched right now
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			bundleValid_o <= 1'b0;
		else
			bundleValid_o <= fetchValid_i && !squash_i;
	end

	// loading and running never overlap
	noWriteDuringFetch: assert property (@(posedge clock_i) disable iff (reset_i)
		!(cacheWrite_i && fetchValid_i));

endmodule

//--- src/laneDecoder.sv
`timescale 1ns/1ps

module laneDecoder (
	input  logic clock_i,
	input  logic reset_i,
	input  logic valid_i,
	input  logic [coreTypesPkg::InstrWidth-1:0] instr_i,
	input  logic [coreTypesPkg::PcWidth-1:0] bundlePc_i,
	input  logic [coreTypesPkg::DataWidth-1:0] rs1Data_i,
	input  logic [coreTypesPkg::DataWidth-1:0] rs2Data_i,
	output logic [coreTypesPkg::RegAddrWidth-1:0] rs1Addr_o,
	output logic [coreTypesPkg::RegAddrWidth-1:0] rs2Addr_o,
	output logic branchTaken_o,
	output logic [coreTypesPkg::PcWidth-1:0] branchTarget_o,
	output logic haltSeen_o,
	output logic opValid_o,
	output logic [6:0] opCode_o,
	output logic [coreTypesPkg::RegAddrWidth-1:0] rd_o,
	output logic [coreTypesPkg::DataWidth-1:0] opA_o,
	output logic [coreTypesPkg::DataWidth-1:0] opB_o
);
	coreTypesPkg::instrWord_u instr;
	logic [6:0] opcode;
	logic isArith;
	logic writesRd;
	logic [coreTypesPkg::DataWidth-1:0] immExt;
	logic [coreTypesPkg::DataWidth-1:0] secondOperand;

	assign instr = instr_i;

	// opcode, rd and rs1 sit in the same place in both views
	assign opcode = instr.regReg.opcode;
	assign isArith = opcode inside {coreTypesPkg::OpAdd, coreTypesPkg::OpSub,
		coreTypesPkg::OpAnd, coreTypesPkg::OpOr, coreTypesPkg::OpXor};
	assign writesRd = isArith && (instr.regReg.rd != '0);

	assign immExt = {{(coreTypesPkg::DataWidth - coreTypesPkg::ImmWidth)
		{instr.regImm.imm[coreTypesPkg::ImmWidth-1]}}, instr.regImm.imm};
	assign secondOperand = instr.regReg.format ? immExt : rs2Data_i;

	// operand reads, bypass happens in the register file
	assign rs1Addr_o = instr.regReg.rs1;
	assign rs2Addr_o = instr.regReg.rs2;

	////////////////////
	// branch and halt
	////////////////////

	// offset counts bundles, eight bytes each
	assign branchTaken_o = (opcode == coreTypesPkg::OpBeqz) && (rs1Data_i == '0);
	assign branchTarget_o = bundlePc_i + {immExt[coreTypesPkg::PcWidth-4:0], 3'b000};
	assign haltSeen_o = opcode == coreTypesPkg::OpHalt;

	always_ff @(posedge clock_i)
	begin
		if (reset_i)
			opValid_o <= 1'b0;
		else
			opValid_o <= valid_i;
	end

	// branch, halt, nop and r0 targets all leave as a nop to r0
	always_ff @(posedge clock_i)
	begin
		opCode_o <= writesRd ? opcode : coreTypesPkg::OpNop;
		rd_o <= writesRd ? instr.regReg.rd : '0;
		opA_o <= rs1Data_i;
		opB_o <= secondOperand;
	end

endmodule

//--- src/registerFile.sv
`timescale 1ns/1ps

module registerFile (
	input  logic clock_i,
	input  logic reset_i,
	input  logic writeEnableA_i,
	input  logic [coreTypesPkg::RegAddrWidth-1:0] writeAddrA_i,
	input  logic [coreTypesPkg::DataWidth-1:0] writeDataA_i,
	input  logic writeEnableB_i,
	input  logic [coreTypesPkg::RegAddrWidth-1:0] writeAddrB_i,
	input  logic [coreTypesPkg::DataWidth-1:0] writeDataB_i,
	input  logic [coreTypesPkg::RegAddrWidth-1:0] readAddrA1_i,
	input  logic [coreTypesPkg::RegAddrWidth-1:0] readAddrA2_i,
	input  logic [coreTypesPkg::RegAddrWidth-1:0] readAddrB1_i,
	input  logic [coreTypesPkg::RegAddrWidth-1:0] readAddrB2_i,
	output logic [coreTypesPkg::DataWidth-1:0] readDataA1_o,
	output logic [coreTypesPkg::DataWidth-1:0] readDataA2_o,
	output logic [coreTypesPkg::DataWidth-1:0] readDataB1_o,
	output logic [coreTypesPkg::DataWidth-1:0] readDataB2_o
);
	logic [coreTypesPkg::DataWidth-1:0] regs [coreTypesPkg::RegCount];

	// write ports carry the execute results, so they double as bypass
	// lane b is younger in program order and wins a tie
	function automatic logic [coreTypesPkg::DataWidth-1:0] readPort(
		input logic [coreTypesPkg::RegAddrWidth-1:0] addr);
		logic [coreTypesPkg::DataWidth-1:0] value;
		if (addr == '0)
			value = '0;
		else if (writeEnableB_i && (writeAddrB_i == addr))
			value = writeDataB_i;
		else if (writeEnableA_i && (writeAddrA_i == addr))
			value = writeDataA_i;
		else
			value = regs[addr];
		return value;
	endfunction

	always_comb
	begin
		readDataA1_o = readPort(readAddrA1_i);
		readDataA2_o = readPort(readAddrA2_i);
		readDataB1_o = readPort(readAddrB1_i);
		readDataB2_o = readPort(readAddrB2_i);
	end

	// b after a, same address keeps b
	always_ff @(posedge clock_i)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < coreTypesPkg::RegCount; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (writeEnableA_i)
				regs[writeAddrA_i] <= writeDataA_i;
			if (writeEnableB_i)
				regs[writeAddrB_i] <= writeDataB_i;
		end
	end

endmodule

//--- src/vliwCore.sv
`timescale 1ns/1ps

module vliwCore #(
	parameter int CacheLines = 16,
	parameter int CreditCount = 4
) (
	input  logic clock_i,
	input  logic reset_i,
	// byte loader, only while run_i is low
	input  logic shiftValid_i,
	input  logic [7:0] shiftByte_i,
	input  logic lineWrite_i,
	input  logic [$clog2(CacheLines)-1:0] lineAddr_i,
	input  logic run_i,
	// one pulse per returned credit
	input  logic creditReturn_i,
	// writeback beat, one per bundle
	output logic wbValid_o,
	output logic wbEnableA_o,
	output logic [coreTypesPkg::RegAddrWidth-1:0] wbAddrA_o,
	output logic [coreTypesPkg::DataWidth-1:0] wbDataA_o,
	output logic wbEnableB_o,
	output logic [coreTypesPkg::RegAddrWidth-1:0] wbAddrB_o,
	output logic [coreTypesPkg::DataWidth-1:0] wbDataB_o,
	output logic halted_o
);
	// fetch
	logic fetchValid;
	logic [coreTypesPkg::PcWidth-1:0] fetchPc;
	logic squash;
	logic [coreTypesPkg::BundleWidth-1:0] bundle;
	logic [coreTypesPkg::PcWidth-1:0] bundlePc;
	logic bundleValid;

	// cache fill
	logic cacheWrite;
	logic [$clog2(CacheLines)-1:0] cacheWriteAddr;
	logic [coreTypesPkg::LineWidth-1:0] cacheWriteLine;

	// lane b branch path
	logic branchTaken;
	logic [coreTypesPkg::PcWidth-1:0] branchTarget;
	logic haltSeen;

	// register reads
	logic [coreTypesPkg::RegAddrWidth-1:0] rs1AddrA, rs2AddrA, rs1AddrB, rs2AddrB;
	logic [coreTypesPkg::DataWidth-1:0] rs1DataA, rs2DataA, rs1DataB, rs2DataB;

	// decoded operations
	logic opValidA, opValidB;
	logic [6:0] opCodeA, opCodeB;
	logic [coreTypesPkg::RegAddrWidth-1:0] rdA, rdB;
	logic [coreTypesPkg::DataWidth-1:0] opFirstA, opSecondA, opFirstB, opSecondB;

	// execute results, also the bypass
	logic resultValidA, resultValidB;
	logic [coreTypesPkg::RegAddrWidth-1:0] resultAddrA, resultAddrB;
	logic [coreTypesPkg::DataWidth-1:0] resultA, resultB;

	coreControl #(.CreditCount(CreditCount)) control (
		.clock_i(clock_i), .reset_i(reset_i), .run_i(run_i),
		.creditReturn_i(creditReturn_i), .bundleValid_i(bundleValid),
		.branchTaken_i(branchTaken), .branchTarget_i(branchTarget), .haltSeen_i(haltSeen),
		.fetchValid_o(fetchValid), .fetchPc_o(fetchPc), .squash_o(squash), .halted_o(halted_o)
	);

	icacheLoader #(.CacheLines(CacheLines)) loader (
		.clock_i(clock_i), .reset_i(reset_i),
		.shiftValid_i(shiftValid_i), .shiftByte_i(shiftByte_i),
		.lineWrite_i(lineWrite_i), .lineAddr_i(lineAddr_i),
		.cacheWrite_o(cacheWrite), .cacheWriteAddr_o(cacheWriteAddr),
		.cacheWriteLine_o(cacheWriteLine)
	);

	instructionCache #(.CacheLines(CacheLines)) icache (
		.clock_i(clock_i), .reset_i(reset_i),
		.cacheWrite_i(cacheWrite), .cacheWriteAddr_i(cacheWriteAddr),
		.cacheWriteLine_i(cacheWriteLine),
		.fetchValid_i(fetchValid), .fetchPc_i(fetchPc), .squash_i(squash),
		.bundle_o(bundle), .bundlePc_o(bundlePc), .bundleValid_o(bundleValid)
	);

	// lane a sits in the low word, its branch outputs stay open
	laneDecoder laneA (
		.clock_i(clock_i), .reset_i(reset_i), .valid_i(bundleValid),
		.instr_i(bundle[coreTypesPkg::InstrWidth-1:0]), .bundlePc_i(bundlePc),
		.rs1Data_i(rs1DataA), .rs2Data_i(rs2DataA),
		.rs1Addr_o(rs1AddrA), .rs2Addr_o(rs2AddrA),
		.branchTaken_o(), .branchTarget_o(), .haltSeen_o(),
		.opValid_o(opValidA), .opCode_o(opCodeA), .rd_o(rdA),
		.opA_o(opFirstA), .opB_o(opSecondA)
	);

	laneDecoder laneB (
		.clock_i(clock_i), .reset_i(reset_i), .valid_i(bundleValid),
		.instr_i(bundle[coreTypesPkg::BundleWidth-1:coreTypesPkg::InstrWidth]),
		.bundlePc_i(bundlePc),
		.rs1Data_i(rs1DataB), .rs2Data_i(rs2DataB),
		.rs1Addr_o(rs1AddrB), .rs2Addr_o(rs2AddrB),
		.branchTaken_o(branchTaken), .branchTarget_o(branchTarget), .haltSeen_o(haltSeen),
		.opValid_o(opValidB), .opCode_o(opCodeB), .rd_o(rdB),
		.opA_o(opFirstB), .opB_o(opSecondB)
	);

	registerFile regFile (
		.clock_i(clock_i), .reset_i(reset_i),
		.writeEnableA_i(resultValidA), .writeAddrA_i(resultAddrA), .writeDataA_i(resultA),
		.writeEnableB_i(resultValidB), .writeAddrB_i(resultAddrB), .writeDataB_i(resultB),
		.readAddrA1_i(rs1AddrA), .readAddrA2_i(rs2AddrA),
		.readAddrB1_i(rs1AddrB), .readAddrB2_i(rs2AddrB),
		.readDataA1_o(rs1DataA), .readDataA2_o(rs2DataA),
		.readDataB1_o(rs1DataB), .readDataB2_o(rs2DataB)
	);

	// lane a carries the beat valid for the bundle
	arithmeticUnit aluA (
		.clock_i(clock_i), .reset_i(reset_i),
		.opValid_i(opValidA), .opCode_i(opCodeA), .rd_i(rdA),
		.opA_i(opFirstA), .opB_i(opSecondA),
		.resultValid_o(resultValidA), .resultAddr_o(resultAddrA), .result_o(resultA),
		.wbValid_o(wbValid_o), .wbEnable_o(wbEnableA_o),
		.wbAddr_o(wbAddrA_o), .wbData_o(wbDataA_o)
	);

	arithmeticUnit aluB (
		.clock_i(clock_i), .reset_i(reset_i),
		.opValid_i(opValidB), .opCode_i(opCodeB), .rd_i(rdB),
		.opA_i(opFirstB), .opB_i(opSecondB),
		.resultValid_o(resultValidB), .resultAddr_o(resultAddrB), .result_o(resultB),
		.wbValid_o(), .wbEnable_o(wbEnableB_o),
		.wbAddr_o(wbAddrB_o), .wbData_o(wbDataB_o)
	);

endmodule

//--- include/testProgram.svh
`ifndef TEST_PROGRAM_SVH
`define TEST_PROGRAM_SVH

// expected beat {enableA, addrA, dataA, enableB, addrB, dataB}
// address and data read zero while the enable is low
localparam int BeatWidth = 2 * (1 + coreTypesPkg::RegAddrWidth + coreTypesPkg::DataWidth);
localparam int ProgramLength = 13;
localparam int ModelStepLimit = 256;

function automatic logic [31:0] encRR(input logic [6:0] op, input int rd, input int rs1,
	input int rs2);
	return {op, 1'b0, rd[4:0], rs1[4:0], rs2[4:0], 9'd0};
endfunction

function automatic logic [31:0] encRI(input logic [6:0] op, input int rd, input int rs1,
	input int imm);
	return {op, 1'b1, rd[4:0], rs1[4:0], imm[13:0]};
endfunction

////////////////////
// program
////////////////////

// lane b in the upper word, bundle n lives at byte 8n
localparam logic [63:0] ProgramBundles [ProgramLength] = '{
	// r1 = 5, r2 = -3
	{encRI(coreTypesPkg::OpAdd, 2, 0, -3), encRI(coreTypesPkg::OpAdd, 1, 0, 5)},
	// both read r1 and r2 through the bypass
	{encRR(coreTypesPkg::OpSub, 4, 1, 2), encRR(coreTypesPkg::OpAdd, 3, 1, 2)},
	// both write r1, lane b keeps it
	{encRI(coreTypesPkg::OpAdd, 1, 4, -1), encRI(coreTypesPkg::OpAdd, 1, 3, 10)},
	{encRR(coreTypesPkg::OpAnd, 6, 4, 2), encRR(coreTypesPkg::OpXor, 5, 1, 3)},
	// lane b reads r8 before lane a updates it
	{encRR(coreTypesPkg::OpAdd, 9, 8, 0), encRI(coreTypesPkg::OpAdd, 8, 8, 1)},
	// loop counter
	{32'd0, encRI(coreTypesPkg::OpAdd, 10, 0, 3)},
	// loop body
	{encRI(coreTypesPkg::OpAdd, 11, 11, 2), encRI(coreTypesPkg::OpAdd, 10, 10, -1)},
	// exit once the counter reaches zero
	{encRI(coreTypesPkg::OpBeqz, 0, 10, 2), encRR(coreTypesPkg::OpOr, 7, 11, 10)},
	// always back to the body
	{encRI(coreTypesPkg::OpBeqz, 0, 0, -2), 32'd0},
	// skip over the next bundle
	{encRI(coreTypesPkg::OpBeqz, 0, 0, 2), encRI(coreTypesPkg::OpAdd, 12, 11, 100)},
	{32'd0, encRI(coreTypesPkg::OpAdd, 13, 0, 99)},
	{encRR(coreTypesPkg::OpHalt, 0, 0, 0), encRI(coreTypesPkg::OpAdd, 14, 0, -100)},
	// never reached
	{32'd0, encRI(coreTypesPkg::OpAdd, 15, 0, 1)}
};

////////////////////
// reference model
////////////////////

function automatic logic [15:0] modelAlu(input logic [6:0] op, input logic [15:0] a,
	input logic [15:0] b);
	case (op)
		coreTypesPkg::OpAdd: return a + b;
		coreTypesPkg::OpSub: return a - b;
		coreTypesPkg::OpAnd: return a & b;
		coreTypesPkg::OpOr: return a | b;
		coreTypesPkg::OpXor: return a ^ b;
		default: return '0;
	endcase
endfunction

// walks the program in order, one beat per executed bundle
task automatic buildExpected(ref logic [BeatWidth-1:0] expQ[$]);
	logic [coreTypesPkg::DataWidth-1:0] regs [coreTypesPkg::RegCount];
	coreTypesPkg::instrWord_u lane [2];
	logic [coreTypesPkg::DataWidth-1:0] value [2];
	logic signed [coreTypesPkg::DataWidth-1:0] immValue;
	logic [coreTypesPkg::DataWidth-1:0] operandB;
	logic [coreTypesPkg::RegAddrWidth-1:0] rd [2];
	logic write [2];
	logic taken;
	int pc;
	int steps;
	foreach (regs[i])
		regs[i] = '0;
	expQ.delete();
	pc = 0;
	steps = 0;
	while (steps < ModelStepLimit && pc >= 0 && pc / 8 < ProgramLength)
	begin
		lane[0] = ProgramBundles[pc / 8][31:0];
		lane[1] = ProgramBundles[pc / 8][63:32];
		for (int l = 0; l < 2; l++)
		begin
			// immediate widened with its sign
			immValue = $signed(lane[l].regImm.imm);
			// both lanes see the values from before this bundle
			operandB = lane[l].regReg.format ? immValue : regs[lane[l].regReg.rs2];
			value[l] = modelAlu(lane[l].regReg.opcode, regs[lane[l].regReg.rs1], operandB);
			write[l] = (lane[l].regReg.opcode inside {coreTypesPkg::OpAdd,
				coreTypesPkg::OpSub, coreTypesPkg::OpAnd, coreTypesPkg::OpOr,
				coreTypesPkg::OpXor}) && (lane[l].regReg.rd != '0);
			rd[l] = write[l] ? lane[l].regReg.rd : '0;
			value[l] = write[l] ? value[l] : '0;
		end
		taken = (lane[1].regReg.opcode == coreTypesPkg::OpBeqz)
			&& (regs[lane[1].regReg.rs1] == '0);
		expQ.push_back({write[0], rd[0], value[0], write[1], rd[1], value[1]});
		if (write[0])
			regs[rd[0]] = value[0];
		if (write[1])
			regs[rd[1]] = value[1];
		if (lane[1].regReg.opcode == coreTypesPkg::OpHalt)
			break;
		pc = taken ? pc + 8 * int'($signed(lane[1].regImm.imm)) : pc + 8;
		steps++;
	end
endtask

`endif

//--- verification/vliwCoreTb.sv
`timescale 1ns/1ps

module vliwCoreTb;

	localparam int CacheLines = 16;
	localparam int CreditCount = 4;
	localparam int AddrWidth = $clog2(CacheLines);
	localparam int DrainTimeout = 3000;
	localparam int QuietCycles = 40;
	localparam int Seed = 32'h28cc;

	// program words and the beat layout
	`include "testProgram.svh"

	localparam int LoadLines = (ProgramLength + coreTypesPkg::BundlesPerLine - 1)
		/ coreTypesPkg::BundlesPerLine;

	logic clock_i;
	logic reset_i;
	logic shiftValid_i;
	logic [7:0] shiftByte_i;
	logic lineWrite_i;
	logic [AddrWidth-1:0] lineAddr_i;
	logic run_i;
	logic creditReturn_i;
	logic wbValid_o;
	logic wbEnableA_o;
	logic [coreTypesPkg::RegAddrWidth-1:0] wbAddrA_o;
	logic [coreTypesPkg::DataWidth-1:0] wbDataA_o;
	logic wbEnableB_o;
	logic [coreTypesPkg::RegAddrWidth-1:0] wbAddrB_o;
	logic [coreTypesPkg::DataWidth-1:0] wbDataB_o;
	logic halted_o;

	// expected beats, head is what the sink waits for
	logic [BeatWidth-1:0] expQ [$];
	logic [BeatWidth-1:0] expectedBeat;
	logic expectPending;
	logic drained;
	int beatsSeen;
	int creditsReturned;

	logic expEnableA;
	logic [coreTypesPkg::RegAddrWidth-1:0] expAddrA;
	logic [coreTypesPkg::DataWidth-1:0] expDataA;
	logic expEnableB;
	logic [coreTypesPkg::RegAddrWidth-1:0] expAddrB;
	logic [coreTypesPkg::DataWidth-1:0] expDataB;

	assign {expEnableA, expAddrA, expDataA, expEnableB, expAddrB, expDataB} = expectedBeat;

	vliwCore #(.CacheLines(CacheLines), .CreditCount(CreditCount)) u_vliwCore (
		.clock_i(clock_i), .reset_i(reset_i),
		.shiftValid_i(shiftValid_i), .shiftByte_i(shiftByte_i),
		.lineWrite_i(lineWrite_i), .lineAddr_i(lineAddr_i),
		.run_i(run_i), .creditReturn_i(creditReturn_i),
		.wbValid_o(wbValid_o),
		.wbEnableA_o(wbEnableA_o), .wbAddrA_o(wbAddrA_o), .wbDataA_o(wbDataA_o),
		.wbEnableB_o(wbEnableB_o), .wbAddrB_o(wbAddrB_o), .wbDataB_o(wbDataB_o),
		.halted_o(halted_o)
	);

	initial
	begin
		clock_i = 1'b0;
		forever
			#10 clock_i = ~clock_i;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1, "run stopped");
	endtask

	task automatic reportMismatch(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		failRun($sformatf("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name,
			actual, expected));
	endtask

	// inputs change 2 ns after the edge
	task automatic stepCycle();
		@(posedge clock_i);
		#2;
	endtask

	////////////////////
	// stimulus
	////////////////////

	// first byte of a line goes in first, unused bundles are nops
	task automatic loadProgram();
		logic [coreTypesPkg::BundleWidth-1:0] bundleWord;
		int index;
		for (int line = 0; line < LoadLines; line++)
		begin
			for (int b = 0; b < coreTypesPkg::LineBytes; b++)
			begin
				index = line * coreTypesPkg::BundlesPerLine + b / 8;
				bundleWord = (index < ProgramLength) ? ProgramBundles[index] : '0;
				shiftValid_i = 1'b1;
				shiftByte_i = bundleWord[8 * (b % 8) +: 8];
				stepCycle();
			end
			shiftValid_i = 1'b0;
			lineWrite_i = 1'b1;
			lineAddr_i = AddrWidth'(line);
			stepCycle();
			lineWrite_i = 1'b0;
		end
	endtask

	task automatic waitForDrain();
		int cycles;
		cycles = 0;
		while (!drained && cycles < DrainTimeout)
		begin
			stepCycle();
			cycles++;
		end
		if (!drained)
			failRun("timeout waiting for the last writeback beat");
	endtask

	initial
	begin
		reset_i = 1'b1;
		shiftValid_i = 1'b0;
		shiftByte_i = '0;
		lineWrite_i = 1'b0;
		lineAddr_i = '0;
		run_i = 1'b0;
		buildExpected(expQ);
		repeat (10)
			stepCycle();
		reset_i = 1'b0;
		loadProgram();
		// let the last line write settle
		repeat (3)
			stepCycle();
		run_i = 1'b1;
		waitForDrain();
		// halted core stays quiet
		repeat (QuietCycles)
			stepCycle();
		$display("Finished with no errors");
		$finish;
	end

	////////////////////
	// credit sink
	////////////////////

	// pops a beat just after the negedge checks have looked at it
	initial
	begin
		beatsSeen = 0;
		drained = 1'b0;
		expectPending = 1'b0;
		expectedBeat = '0;
		forever
		begin
			@(negedge clock_i);
			#1;
			if (!reset_i && wbValid_o && expQ.size() != 0)
			begin
				beatsSeen++;
				void'(expQ.pop_front());
				if (expQ.size() == 0)
					drained = 1'b1;
			end
			expectPending = expQ.size() != 0;
			expectedBeat = expectPending ? expQ[0] : '0;
		end
	end

	// owed credits trickle back, about one cycle in four
	initial
	begin
		void'($urandom(Seed));
		creditsReturned = 0;
		creditReturn_i = 1'b0;
		forever
		begin
			stepCycle();
			if (!reset_i && beatsSeen > creditsReturned && ($urandom % 4) == 0)
			begin
				creditReturn_i = 1'b1;
				creditsReturned++;
			end
			else
				creditReturn_i = 1'b0;
		end
	end

	////////////////////
	// checks
	////////////////////

	// outputs are settled at the falling edge
	idleBeforeRun: assert property (@(negedge clock_i) disable iff (reset_i)
		!run_i |-> !wbValid_o && !halted_o)
		else failRun("writeback or halt seen before run_i was raised");

	beatExpected: assert property (@(negedge clock_i) disable iff (reset_i)
		wbValid_o |-> expectPending)
		else failRun("writeback beat arrived with no beat left to expect");

	creditLimit: assert property (@(negedge clock_i) disable iff (reset_i)
		wbValid_o |-> beatsSeen < creditsReturned + CreditCount)
		else failRun("writeback beats ran ahead of the credits handed out");

	enableAMatch: assert property (@(negedge clock_i) disable iff (reset_i)
		wbValid_o && expectPending |-> wbEnableA_o == expEnableA)
		else reportMismatch("wbEnableA_o", 16'(wbEnableA_o), 16'(expEnableA));

	addrAMatch: assert property (@(negedge clock_i) disable iff (reset_i)
		wbValid_o && expectPending |-> wbAddrA_o == expAddrA)
		else reportMismatch("wbAddrA_o", 16'(wbAddrA_o), 16'(expAddrA));

	dataAMatch: assert property (@(negedge clock_i) disable iff (reset_i)
		wbValid_o && expectPending |-> wbDataA_o == expDataA)
		else reportMismatch("wbDataA_o", wbDataA_o, expDataA);

	enableBMatch: assert property (@(negedge clock_i) disable iff (reset_i)
		wbValid_o && expectPending |-> wbEnableB_o == expEnableB)
		else reportMismatch("wbEnableB_o", 16'(wbEnableB_o), 16'(expEnableB));

	addrBMatch: assert property (@(negedge clock_i) disable iff (reset_i)
		wbValid_o && expectPending |-> wbAddrB_o == expAddrB)
		else reportMismatch("wbAddrB_o", 16'(wbAddrB_o), 16'(expAddrB));

	dataBMatch: assert property (@(negedge clock_i) disable iff (reset_i)
		wbValid_o && expectPending |-> wbDataB_o == expDataB)
		else reportMismatch("wbDataB_o", wbDataB_o, expDataB);

	// after the halt bundle's beat nothing else may come out
	haltAfterDrain: assert property (@(negedge clock_i) disable iff (reset_i)
		drained |-> halted_o && !wbValid_o)
		else failRun("core not halted or still writing back after the halt bundle");

endmodule
